//--- all.f
+incdir+hdl
hdl/spi_pkg.sv
hdl/spi_shift_rx.sv
hdl/spi_shift_tx.sv
hdl/spi_sync.sv
hdl/spi_sck_gen.sv
hdl/spi_master_ctrl.sv
hdl/spi_master.sv
hdl/spi_slave.sv
hdl/spi_link_top.sv
tests/tb_spi_link.sv

//--- hdl/spi_link_top.sv
`timescale 1ns/1ps
`default_nettype none

module spi_link_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               m_en,
    input  spi_pkg::spi_byte_t m_wd,
    input  spi_pkg::spi_byte_t s_wd,
    output spi_pkg::spi_byte_t m_rd,
    output logic               m_rdy,
    output logic               m_busy,
    output spi_pkg::spi_byte_t s_rd,
    output logic               s_rdy,
    output logic               s_busy
);
    import spi_pkg::*;

    spi_bus_t bus;
    logic     miso;

    spi_master u_master (
        .clk  (clk),
        .rst  (rst),
        .en   (m_en),
        .wd   (m_wd),
        .miso (miso),
        .bus  (bus),
        .rd   (m_rd),
        .rdy  (m_rdy),
        .busy (m_busy)
    );

    spi_slave u_slave (
        .clk  (clk),
        .rst  (rst),
        .bus  (bus),
        .wd   (s_wd),
        .miso (miso),
        .rd   (s_rd),
        .rdy  (s_rdy),
        .busy (s_busy)
    );

endmodule

`default_nettype wire

//--- hdl/spi_master.sv
`timescale 1ns/1ps
`default_nettype none

`include "spi_params.svh"

module spi_master #(
    parameter int SCK_HALF_CLKS = `SPI_SCK_HALF_CLKS
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               en,
    input  spi_pkg::spi_byte_t wd,
    input  logic               miso,
    output spi_pkg::spi_bus_t  bus,
    output spi_pkg::spi_byte_t rd,
    output logic               rdy,
    output logic               busy
);
    import spi_pkg::*;

    logic         ss;
    logic         sck_en;
    logic         sck;
    logic         mosi;
    logic         shift_clr;
    spi_rx_word_t rx_word;
    spi_rx_word_t rx_sync;

    spi_master_ctrl u_ctrl (
        .clk    (clk),
        .rst    (rst),
        .en     (en),
        .sck    (sck),
        .ss     (ss),
        .sck_en (sck_en)
    );

    spi_sck_gen #(.HALF_CLKS(SCK_HALF_CLKS)) u_sck_gen (
        .clk (clk),
        .rst (rst),
        .en  (sck_en),
        .sck (sck)
    );

    // Shifters idle while the slave is deselected
    assign shift_clr = rst | ss;

    spi_shift_rx u_rx (
        .sdi  (miso),
        .sck  (sck),
        .clr  (shift_clr),
        .word (rx_word)
    );

    spi_sync #(.T(spi_rx_word_t)) u_rx_sync (
        .clk (clk),
        .rst (rst),
        .d   (rx_word),
        .q   (rx_sync)
    );

    // Receive buffer, rdy drops when the next transfer selects
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rdy <= 1'b0;
            rd  <= '0;
        end else if (rx_sync.done) begin
            rdy <= 1'b1;
            rd  <= rx_sync.data;
        end else if (!ss) begin
            rdy <= 1'b0;
        end
    end

    spi_shift_tx u_tx (
        .wd   (wd),
        .sck  (sck),
        .ld   (shift_clr),
        .sdo  (mosi),
        .busy ()
    );

    assign bus  = '{sck: sck, ss: ss, mosi: mosi};
    assign busy = ~ss | sck_en;

endmodule

`default_nettype wire

//--- hdl/spi_master_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "spi_params.svh"

module spi_master_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic en,
    input  logic sck,
    output logic ss,
    output logic sck_en
);
    import spi_pkg::*;

    localparam int CNT_W = $clog2(`SPI_DATA_W + 1);

    typedef enum logic [1:0] {
        IDLE,
        SELECT,
        GEN_CLK
    } state_t;

    state_t           state_q;
    logic [CNT_W-1:0] bit_cnt;
    logic             cnt_clr;
    logic             last;
    spi_ctrl_async_t  ctrl_raw;
    spi_ctrl_async_t  ctrl_sync;

    // Rising sck edges of the current byte
    assign cnt_clr = ~sck_en;
    assign last    = (bit_cnt == CNT_W'(`SPI_DATA_W));

    always_ff @(posedge sck or posedge cnt_clr) begin
        if (cnt_clr) begin
            bit_cnt <= '0;
        end else if (!last) begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    assign ctrl_raw = '{en: en, last: last};

    spi_sync #(.T(spi_ctrl_async_t)) u_sync (
        .clk (clk),
        .rst (rst),
        .d   (ctrl_raw),
        .q   (ctrl_sync)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE:    state_q <= ctrl_sync.en ? SELECT : IDLE;
                SELECT:  state_q <= GEN_CLK;
                GEN_CLK: state_q <= ctrl_sync.last ? IDLE : GEN_CLK;
                default: state_q <= IDLE;
            endcase
        end
    end

    always_comb begin
        case (state_q)
            SELECT:  {ss, sck_en} = 2'b00;
            GEN_CLK: {ss, sck_en} = 2'b01;
            default: {ss, sck_en} = 2'b10;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/spi_params.svh
`ifndef SPI_PARAMS_SVH
`define SPI_PARAMS_SVH

// Bits per transfer
`define SPI_DATA_W 8

// Default clk cycles per sck half-period
`define SPI_SCK_HALF_CLKS 4

// Flip-flop stages from the sck side into clk
`define SPI_SYNC_STAGES 2

`endif

//--- hdl/spi_pkg.sv
`default_nettype none

`include "spi_params.svh"

package spi_pkg;

    typedef logic [`SPI_DATA_W-1:0] spi_byte_t;

    // Receive shifter result, crosses into clk as one word
    typedef struct packed {
        spi_byte_t data;
        logic      done;
    } spi_rx_word_t;

    // Master to slave wires, miso runs separately
    typedef struct packed {
        logic sck;
        logic ss;
        logic mosi;
    } spi_bus_t;

    typedef struct packed {
        logic en;
        logic last;
    } spi_ctrl_async_t;

endpackage

`default_nettype wire

//--- hdl/spi_sck_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "spi_params.svh"

module spi_sck_gen #(
    parameter int HALF_CLKS = `SPI_SCK_HALF_CLKS
) (
    input  logic clk,
    input  logic rst,
    input  logic en,
    output logic sck
);
    localparam int CNT_W = (HALF_CLKS > 1) ? $clog2(HALF_CLKS) : 1;

    logic [CNT_W-1:0] cnt_q;
    logic             sck_q;

    // Idles high, so the first edge after enable is falling
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt_q <= '0;
            sck_q <= 1'b1;
        end else if (!en) begin
            cnt_q <= '0;
            sck_q <= 1'b1;
        end else if (cnt_q == CNT_W'(HALF_CLKS - 1)) begin
            cnt_q <= '0;
            sck_q <= ~sck_q;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    assign sck = sck_q;

endmodule

`default_nettype wire

//--- hdl/spi_shift_rx.sv
`timescale 1ns/1ps
`default_nettype none

`include "spi_params.svh"

module spi_shift_rx (
    input  logic                 sdi,
    input  logic                 sck,
    input  logic                 clr,
    output spi_pkg::spi_rx_word_t word
);
    import spi_pkg::*;

    localparam int CNT_W = $clog2(`SPI_DATA_W + 1);

    spi_byte_t        data_q;
    logic [CNT_W-1:0] cnt_q;
    logic             full;

    assign full = (cnt_q == CNT_W'(`SPI_DATA_W));

    // MSB first, sampled on rising sck
    always_ff @(posedge sck or posedge clr) begin
        if (clr) begin
            data_q <= '0;
            cnt_q  <= '0;
        end else if (!full) begin
            data_q <= {data_q[`SPI_DATA_W-2:0], sdi};
            cnt_q  <= cnt_q + 1'b1;
        end
    end

    // Held until the next clear
    assign word = '{data: data_q, done: full};

endmodule

`default_nettype wire

//--- hdl/spi_shift_tx.sv
`timescale 1ns/1ps
`default_nettype none

`include "spi_params.svh"

module spi_shift_tx (
    input  spi_pkg::spi_byte_t wd,
    input  logic               sck,
    input  logic               ld,
    output logic               sdo,
    output logic               busy
);
    import spi_pkg::*;

    localparam int CNT_W = $clog2(`SPI_DATA_W + 1);

    spi_byte_t        wd_hold;
    spi_byte_t        shreg;
    logic [CNT_W-1:0] cnt_q;
    logic             sent;

    assign sent = (cnt_q == CNT_W'(`SPI_DATA_W));

    // Follows wd while deselected, frozen once the transfer starts
    always_latch begin
        if (ld) begin
            wd_hold <= wd;
        end
    end

    // Mode 3: the first falling edge only takes over the MSB already on sdo
    always_ff @(negedge sck or posedge ld) begin
        if (ld) begin
            shreg <= '0;
            cnt_q <= '0;
        end else if (!sent) begin
            if (cnt_q == '0) begin
                shreg <= wd_hold;
            end else begin
                shreg <= {shreg[`SPI_DATA_W-2:0], 1'b0};
            end
            cnt_q <= cnt_q + 1'b1;
        end
    end

    assign sdo  = (cnt_q == '0) ? wd_hold[`SPI_DATA_W-1] : shreg[`SPI_DATA_W-1];
    assign busy = ~ld & ~sent;

endmodule

`default_nettype wire

//--- hdl/spi_slave.sv
`timescale 1ns/1ps
`default_nettype none

module spi_slave (
    input  logic               clk,
    input  logic               rst,
    input  spi_pkg::spi_bus_t  bus,
    input  spi_pkg::spi_byte_t wd,
    output logic               miso,
    output spi_pkg::spi_byte_t rd,
    output logic               rdy,
    output logic               busy
);
    import spi_pkg::*;

    logic         shift_clr;
    spi_rx_word_t rx_word;
    spi_rx_word_t rx_sync;

    // Deselect holds both shifters clear
    assign shift_clr = rst | bus.ss;

    spi_shift_rx u_rx (
        .sdi  (bus.mosi),
        .sck  (bus.sck),
        .clr  (shift_clr),
        .word (rx_word)
    );

    spi_sync #(.T(spi_rx_word_t)) u_rx_sync (
        .clk (clk),
        .rst (rst),
        .d   (rx_word),
        .q   (rx_sync)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rdy <= 1'b0;
            rd  <= '0;
        end else if (rx_sync.done) begin
            rdy <= 1'b1;
            rd  <= rx_sync.data;
        end else if (!bus.ss) begin
            rdy <= 1'b0;
        end
    end

    spi_shift_tx u_tx (
        .wd   (wd),
        .sck  (bus.sck),
        .ld   (shift_clr),
        .sdo  (miso),
        .busy (busy)
    );

endmodule

`default_nettype wire

//--- hdl/spi_sync.sv
`timescale 1ns/1ps
`default_nettype none

`include "spi_params.svh"

module spi_sync #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic rst,
    input  T     d,
    output T     q
);
    T stage_q [`SPI_SYNC_STAGES];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `SPI_SYNC_STAGES; i++) begin
                stage_q[i] <= '0;
            end
        end else begin
            stage_q[0] <= d;
            for (int i = 1; i < `SPI_SYNC_STAGES; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    assign q = stage_q[`SPI_SYNC_STAGES-1];

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# Build and run the SPI link testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --timescale 1ns/1ps -f all.f --top-module tb_spi_link \
    -Mdir obj_dir -o tb_spi_link \
    && ./obj_dir/tb_spi_link 2>&1 | tee sim.log \
    || { echo "Build or simulation failed"; exit 1; }

grep -q "Simulation finished: PASS" sim.log \
    && { echo "Result: passed"; exit 0; } \
    || { echo "Result: failed"; exit 1; }

//--- tests/tb_spi_link.sv
`timescale 1ns/1ps
`default_nettype none

module tb_spi_link;
    import spi_pkg::*;

    // Roughly 100 clk cycles per exchange over 25 exchanges, with margin
    localparam int EXCHANGES      = 25;
    localparam int EXCHANGE_CLKS  = 100;
    localparam int TIMEOUT_CYCLES = 2 * EXCHANGES * EXCHANGE_CLKS;
    localparam int WAIT_LIMIT     = EXCHANGE_CLKS;

    logic      clk;
    logic      rst;
    logic      m_en;
    spi_byte_t m_wd;
    spi_byte_t s_wd;
    spi_byte_t m_rd;
    logic      m_rdy;
    logic      m_busy;
    spi_byte_t s_rd;
    logic      s_rdy;
    logic      s_busy;

    int errors;
    int tests_run;
    int tests_failed;
    int cycles;

    spi_link_top u_dut (
        .clk    (clk),
        .rst    (rst),
        .m_en   (m_en),
        .m_wd   (m_wd),
        .s_wd   (s_wd),
        .m_rd   (m_rd),
        .m_rdy  (m_rdy),
        .m_busy (m_busy),
        .s_rd   (s_rd),
        .s_rdy  (s_rdy),
        .s_busy (s_busy)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Drive and sample 1 ns after the rising edge
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic check_byte(input string name, input spi_byte_t got, input spi_byte_t exp);
        assert (got == exp) else begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        assert (got == exp) else begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    function automatic logic level_of(input string name);
        case (name)
            "m_busy": return m_busy;
            "m_rdy":  return m_rdy;
            "s_rdy":  return s_rdy;
            default:  return 1'b0;
        endcase
    endfunction

    task automatic wait_for(input string name, input logic level, output bit ok);
        int n;
        n = 0;
        while (level_of(name) != level && n < WAIT_LIMIT) begin
            tick();
            n++;
        end
        ok = (level_of(name) == level);
        assert (ok) else begin
            $display("Error: %s did not reach %0b within %0d cycles", name, level, WAIT_LIMIT);
            errors++;
        end
    endtask

    task automatic pulse_en();
        m_en = 1'b1;
        tick();
        m_en = 1'b0;
    endtask

    // Returns once the slave is selected and the old rdy has dropped
    task automatic start_exchange(input spi_byte_t mw, input spi_byte_t sw, output bit ok);
        m_wd = mw;
        s_wd = sw;
        pulse_en();
        wait_for("m_busy", 1'b1, ok);
        if (ok) begin
            wait_for("m_rdy", 1'b0, ok);
        end
    endtask

    task automatic run_exchange(input spi_byte_t mw, input spi_byte_t sw, output bit ok);
        start_exchange(mw, sw, ok);
        if (ok) begin
            wait_for("m_rdy", 1'b1, ok);
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - err_before);
        end
    endtask

    task automatic test_reset();
        int e0;
        e0 = errors;
        check_bit("m_rdy", m_rdy, 1'b0);
        check_bit("s_rdy", s_rdy, 1'b0);
        check_bit("m_busy", m_busy, 1'b0);
        check_bit("s_busy", s_busy, 1'b0);
        check_byte("m_rd", m_rd, 8'h00);
        check_byte("s_rd", s_rd, 8'h00);
        report_test("reset", e0);
    endtask

    task automatic test_single();
        int e0;
        bit ok;
        e0 = errors;
        run_exchange(8'hA5, 8'h3C, ok);
        if (ok) begin
            check_byte("m_rd", m_rd, 8'h3C);
            check_byte("s_rd", s_rd, 8'hA5);
            check_bit("s_rdy", s_rdy, 1'b1);
        end
        report_test("single_exchange", e0);
    endtask

    task automatic test_busy();
        int e0;
        int n;
        bit ok;
        e0 = errors;
        start_exchange(8'h5A, 8'hC3, ok);
        n = 0;
        while (ok && !m_rdy && n < WAIT_LIMIT) begin
            check_bit("m_busy", m_busy, 1'b1);
            // Second request well inside the transfer
            m_en = (n == 10);
            tick();
            n++;
        end
        m_en = 1'b0;
        if (ok) begin
            wait_for("m_rdy", 1'b1, ok);
        end
        if (ok) begin
            check_bit("m_busy", m_busy, 1'b0);
            repeat (20) begin
                tick();
                check_bit("m_busy", m_busy, 1'b0);
            end
            check_bit("m_rdy", m_rdy, 1'b1);
            check_byte("m_rd", m_rd, 8'hC3);
            check_byte("s_rd", s_rd, 8'hA5 ^ 8'hFF);
        end
        report_test("busy", e0);
    endtask

    task automatic test_rdy_clear();
        int e0;
        bit ok;
        e0 = errors;
        check_bit("m_rdy", m_rdy, 1'b1);
        check_bit("s_rdy", s_rdy, 1'b1);
        start_exchange(8'h96, 8'h69, ok);
        if (ok) begin
            check_bit("s_rdy", s_rdy, 1'b0);
            check_bit("s_busy", s_busy, 1'b1);
            wait_for("m_rdy", 1'b1, ok);
        end
        if (ok) begin
            check_bit("s_rdy", s_rdy, 1'b1);
            check_bit("s_busy", s_busy, 1'b0);
            check_byte("m_rd", m_rd, 8'h69);
            check_byte("s_rd", s_rd, 8'h96);
        end
        report_test("rdy_clear", e0);
    endtask

    task automatic test_hold();
        int e0;
        bit ok;
        e0 = errors;
        start_exchange(8'h81, 8'h7E, ok);
        if (ok) begin
            repeat (3) tick();
            m_wd = 8'hFF;
            s_wd = 8'h00;
            wait_for("m_rdy", 1'b1, ok);
        end
        if (ok) begin
            check_byte("m_rd", m_rd, 8'h7E);
            check_byte("s_rd", s_rd, 8'h81);
        end
        report_test("data_hold", e0);
    endtask

    task automatic test_random();
        int e0;
        bit ok;
        spi_byte_t mw;
        spi_byte_t sw;
        e0 = errors;
        for (int i = 0; i < 20; i++) begin
            mw = spi_byte_t'($urandom());
            sw = spi_byte_t'($urandom());
            run_exchange(mw, sw, ok);
            if (ok) begin
                check_byte("m_rd", m_rd, sw);
                check_byte("s_rd", s_rd, mw);
            end
        end
        report_test("random_exchanges", e0);
    endtask

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: run did not end within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        void'($urandom(5073));
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        rst  = 1'b1;
        m_en = 1'b0;
        m_wd = '0;
        s_wd = '0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        tick();

        test_reset();
        test_single();
        test_busy();
        test_rdy_clear();
        test_hold();
        test_random();

        $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
